/* include/topk_defines.svh */
// ==============================
// Top-K selector widths and depth
// ==============================
`ifndef TOPK_DEFINES_SVH
`define TOPK_DEFINES_SVH

// Width of one stream value
`define TOPK_DATA_WIDTH 32

// Heap slots, power of two
`define TOPK_DEPTH 16

// Bits to address one slot
`define TOPK_ADDR_WIDTH $clog2(`TOPK_DEPTH)

// Fill counter, reaches K and holds child addresses past K
`define TOPK_PTR_WIDTH (`TOPK_ADDR_WIDTH + 2)

`endif

/* src/topk_pkg.sv */
// ==============================
// Top-K selector shared types
// ==============================
`default_nettype none
`include "topk_defines.svh"

package topk_pkg;

    typedef logic [`TOPK_DATA_WIDTH-1:0] payload_t;
    typedef logic [`TOPK_ADDR_WIDTH-1:0] heap_addr_t;
    typedef logic [`TOPK_PTR_WIDTH-1:0] heap_ptr_t;

    // Heap control states
    typedef enum logic [2:0] {
        CLEAR,
        FILL,
        SIFT_UP,
        FULL,
        SIFT_DN,
        EMIT
    } sort_state_e;

endpackage

`default_nettype wire

/* src/heap_port_if.sv */
// ==============================
// One port of the heap RAM
// ==============================
`timescale 1ns/100ps
`default_nettype none

interface heap_port_if;

    topk_pkg::payload_t   wdata;
    topk_pkg::heap_addr_t waddr;
    logic                 wen;
    topk_pkg::heap_addr_t raddr;
    topk_pkg::payload_t   rdata;

    modport driver (output wdata, waddr, wen, raddr, input rdata);
    modport ram    (input wdata, waddr, wen, raddr, output rdata);

    // Watches both directions without driving anything
    modport snoop  (input wdata, waddr, wen, raddr, rdata);

endinterface

`default_nettype wire

/* src/heap_dpram.sv */
// ==============================
// Dual-port heap RAM, K words
// ==============================
`timescale 1ns/100ps
`default_nettype none
`include "topk_defines.svh"

module heap_dpram (
    input wire logic clk,
    heap_port_if.ram port_a,
    heap_port_if.ram port_b
);

    topk_pkg::payload_t mem [`TOPK_DEPTH];

    // Port B is written last, so it wins on an address clash
    always_ff @(posedge clk) begin
        if (port_a.wen) begin
            mem[port_a.waddr] <= port_a.wdata;
        end
        if (port_b.wen) begin
            mem[port_b.waddr] <= port_b.wdata;
        end
    end

    // Registered reads, old data on a same-cycle write
    always_ff @(posedge clk) begin
        port_a.rdata <= mem[port_a.raddr];
        port_b.rdata <= mem[port_b.raddr];
    end

endmodule

`default_nettype wire

/* src/heap_sift_ctrl.sv */
// ==============================
// Heap FSM, sift addressing and
// RAM port muxing
// ==============================
`timescale 1ns/100ps
`default_nettype none
`include "topk_defines.svh"

module heap_sift_ctrl (
    input  wire logic                  clk,
    input  wire logic                  aresetn,
    input  wire logic                  s_tvalid,
    input  wire logic                  s_tlast,
    input  wire topk_pkg::payload_t    s_tdata,
    output logic                       s_tready,
    output logic                       m_tvalid,
    output logic                       m_tlast,
    heap_port_if.driver                port_a,
    heap_port_if.driver                port_b,
    output topk_pkg::sort_state_e      state,
    output logic                       din_take,
    output topk_pkg::heap_addr_t       cmp_a_addr,
    output topk_pkg::heap_addr_t       cmp_b_addr,
    output logic                       right_ovfl,
    output logic                       cmp_invert,
    output logic                       swap_enable,
    input  wire logic                  a_less_b,
    input  wire logic                  swap_execute,
    input  wire logic                  din_gt_top,
    input  wire logic                  swap_at_full,
    input  wire topk_pkg::payload_t    swap_data,
    input  wire topk_pkg::payload_t    min_child,
    input  wire topk_pkg::heap_addr_t  min_child_addr
);

    localparam topk_pkg::heap_ptr_t FULL_CNT  = `TOPK_DEPTH;
    localparam topk_pkg::heap_ptr_t HALF_CNT  = `TOPK_DEPTH / 2;
    localparam topk_pkg::heap_ptr_t LAST_SLOT = `TOPK_DEPTH - 1;

    topk_pkg::heap_ptr_t  heap_ptr;
    topk_pkg::heap_addr_t swap_wb_a_addr;
    topk_pkg::heap_addr_t swap_wb_b_addr;
    topk_pkg::heap_addr_t last_swap_addr;
    topk_pkg::heap_ptr_t  left_leaf;
    topk_pkg::heap_ptr_t  right_leaf;
    logic                 left_ovfl;
    logic                 nxt_right_ovfl;
    logic                 din_valid;
    logic                 din_swap;
    logic                 sift_stage;
    logic                 last_flag;

    // Parent slot of a heap index, meaningless for the root
    function automatic topk_pkg::heap_addr_t parent_of(topk_pkg::heap_ptr_t idx);
        topk_pkg::heap_ptr_t p;
        p = (idx - topk_pkg::heap_ptr_t'(1)) >> 1;
        return p[`TOPK_ADDR_WIDTH-1:0];
    endfunction

    assign din_valid = s_tvalid && s_tready;

    // New value is cached when it starts a sift
    assign din_take = din_valid &&
        (((state == topk_pkg::FILL) && (heap_ptr != '0)) ||
         ((state == topk_pkg::FULL) && din_gt_top));

    // Sift-up puts the child on the left, no inversion needed
    assign cmp_invert = 1'b0;

    // Children of the selected slot for the next sift-down level
    assign left_leaf      = {1'b0, min_child_addr, 1'b0} + topk_pkg::heap_ptr_t'(1);
    assign right_leaf     = {1'b0, min_child_addr, 1'b0} + topk_pkg::heap_ptr_t'(2);
    assign left_ovfl      = left_leaf > LAST_SLOT;
    assign nxt_right_ovfl = right_leaf > LAST_SLOT;

    // Write-back addresses trail the compare addresses by one cycle
    always_ff @(posedge clk) begin
        if (state == topk_pkg::FILL) begin
            swap_wb_a_addr <= heap_ptr[`TOPK_ADDR_WIDTH-1:0];
            swap_wb_b_addr <= parent_of(heap_ptr);
        end else begin
            swap_wb_a_addr <= cmp_a_addr;
            swap_wb_b_addr <= cmp_b_addr;
        end
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            state          <= topk_pkg::CLEAR;
            s_tready       <= 1'b0;
            m_tvalid       <= 1'b0;
            m_tlast        <= 1'b0;
            heap_ptr       <= '0;
            cmp_a_addr     <= '0;
            cmp_b_addr     <= '0;
            swap_enable    <= 1'b0;
            din_swap       <= 1'b0;
            last_swap_addr <= '0;
            sift_stage     <= 1'b0;
            right_ovfl     <= 1'b0;
            last_flag      <= 1'b0;
        end else begin
            case (state)
                topk_pkg::CLEAR: begin
                    m_tvalid  <= 1'b0;
                    m_tlast   <= 1'b0;
                    last_flag <= 1'b0;
                    if (heap_ptr == HALF_CNT) begin
                        heap_ptr <= '0;
                        s_tready <= 1'b1;
                        state    <= topk_pkg::FILL;
                    end else begin
                        heap_ptr <= heap_ptr + topk_pkg::heap_ptr_t'(1);
                    end
                end
                topk_pkg::FILL: begin
                    if (din_valid) begin
                        heap_ptr <= heap_ptr + topk_pkg::heap_ptr_t'(1);
                        if (s_tlast) begin
                            last_flag <= 1'b1;
                        end
                        if (heap_ptr != '0) begin
                            // Next pair is parent and grandparent
                            cmp_a_addr  <= parent_of(heap_ptr);
                            cmp_b_addr  <= parent_of(topk_pkg::heap_ptr_t'(parent_of(heap_ptr)));
                            swap_enable <= 1'b1;
                            s_tready    <= 1'b0;
                            state       <= topk_pkg::SIFT_UP;
                        end else if (s_tlast) begin
                            heap_ptr <= '0;
                            s_tready <= 1'b0;
                            state    <= topk_pkg::EMIT;
                        end
                    end
                end
                topk_pkg::SIFT_UP: begin
                    if (swap_execute) begin
                        cmp_a_addr  <= cmp_b_addr;
                        cmp_b_addr  <= parent_of(topk_pkg::heap_ptr_t'(cmp_b_addr));
                        // A swap at the root ends the climb
                        swap_enable <= (cmp_a_addr != '0);
                    end else begin
                        swap_enable <= 1'b0;
                        if (last_flag) begin
                            heap_ptr <= '0;
                            state    <= topk_pkg::EMIT;
                        end else if (heap_ptr == FULL_CNT) begin
                            cmp_a_addr <= topk_pkg::heap_addr_t'(1);
                            cmp_b_addr <= topk_pkg::heap_addr_t'(2);
                            s_tready   <= 1'b1;
                            state      <= topk_pkg::FULL;
                        end else begin
                            s_tready <= 1'b1;
                            state    <= topk_pkg::FILL;
                        end
                    end
                end
                topk_pkg::FULL: begin
                    if (din_valid) begin
                        if (s_tlast) begin
                            last_flag <= 1'b1;
                        end
                        if (din_gt_top) begin
                            din_swap       <= 1'b1;
                            sift_stage     <= 1'b0;
                            right_ovfl     <= 1'b0;
                            last_swap_addr <= '0;
                            s_tready       <= 1'b0;
                            state          <= topk_pkg::SIFT_DN;
                        end else if (s_tlast) begin
                            // Dropped value closes the stream
                            heap_ptr <= '0;
                            s_tready <= 1'b0;
                            state    <= topk_pkg::EMIT;
                        end
                    end
                end
                topk_pkg::SIFT_DN: begin
                    sift_stage <= !sift_stage;
                    // Stage 0 decides and writes, stage 1 waits for reads
                    if (!sift_stage) begin
                        din_swap       <= 1'b0;
                        right_ovfl     <= nxt_right_ovfl;
                        last_swap_addr <= min_child_addr;
                        if (!left_ovfl) begin
                            cmp_a_addr <= left_leaf[`TOPK_ADDR_WIDTH-1:0];
                        end
                        if (!nxt_right_ovfl) begin
                            cmp_b_addr <= right_leaf[`TOPK_ADDR_WIDTH-1:0];
                        end
                        if (!swap_at_full || left_ovfl) begin
                            if (last_flag) begin
                                heap_ptr <= '0;
                                state    <= topk_pkg::EMIT;
                            end else begin
                                cmp_a_addr <= topk_pkg::heap_addr_t'(1);
                                cmp_b_addr <= topk_pkg::heap_addr_t'(2);
                                s_tready   <= 1'b1;
                                state      <= topk_pkg::FULL;
                            end
                        end
                    end
                end
                topk_pkg::EMIT: begin
                    m_tvalid <= 1'b1;
                    m_tlast  <= (heap_ptr == LAST_SLOT);
                    if (heap_ptr == LAST_SLOT) begin
                        heap_ptr <= '0;
                        state    <= topk_pkg::CLEAR;
                    end else begin
                        heap_ptr <= heap_ptr + topk_pkg::heap_ptr_t'(1);
                    end
                end
                default: begin
                    state <= topk_pkg::CLEAR;
                end
            endcase
        end
    end

    // RAM port selection per state
    always_comb begin
        port_a.wdata = '0;
        port_a.waddr = '0;
        port_a.wen   = 1'b0;
        port_a.raddr = cmp_a_addr;
        port_b.wdata = '0;
        port_b.waddr = '0;
        port_b.wen   = 1'b0;
        port_b.raddr = cmp_b_addr;
        case (state)
            topk_pkg::CLEAR: begin
                // Lower and upper half zeroed together
                port_a.waddr = {1'b0, heap_ptr[`TOPK_ADDR_WIDTH-2:0]};
                port_a.wen   = 1'b1;
                port_b.waddr = {1'b1, heap_ptr[`TOPK_ADDR_WIDTH-2:0]};
                port_b.wen   = 1'b1;
            end
            topk_pkg::FILL: begin
                port_a.wdata = s_tdata;
                port_a.waddr = heap_ptr[`TOPK_ADDR_WIDTH-1:0];
                port_a.wen   = din_valid;
                port_b.raddr = parent_of(heap_ptr);
            end
            topk_pkg::SIFT_UP: begin
                port_a.wdata = port_b.rdata;
                port_a.waddr = swap_wb_a_addr;
                port_a.wen   = swap_execute;
                port_b.wdata = swap_data;
                port_b.waddr = swap_wb_b_addr;
                port_b.wen   = swap_execute;
            end
            topk_pkg::SIFT_DN: begin
                if (!sift_stage) begin
                    port_a.wdata = swap_at_full ? min_child : swap_data;
                    port_a.waddr = last_swap_addr;
                    port_a.wen   = swap_at_full || din_swap;
                    port_b.wdata = swap_data;
                    port_b.wen   = swap_at_full;
                    if (din_swap) begin
                        port_b.waddr = a_less_b ? topk_pkg::heap_addr_t'(1) :
                                                  topk_pkg::heap_addr_t'(2);
                    end else begin
                        port_b.waddr = min_child_addr;
                    end
                end
            end
            topk_pkg::EMIT: begin
                port_a.raddr = heap_ptr[`TOPK_ADDR_WIDTH-1:0];
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/heap_compare.sv */
// ==============================
// Heap comparators, value and
// heap-top caches
// ==============================
`timescale 1ns/100ps
`default_nettype none

module heap_compare (
    input  wire logic                  clk,
    input  wire logic                  aresetn,
    heap_port_if.snoop                 port_a,
    heap_port_if.snoop                 port_b,
    input  wire topk_pkg::sort_state_e state,
    input  wire topk_pkg::payload_t    din_data,
    input  wire logic                  din_take,
    input  wire topk_pkg::heap_addr_t  cmp_a_addr,
    input  wire topk_pkg::heap_addr_t  cmp_b_addr,
    input  wire logic                  right_ovfl,
    input  wire logic                  cmp_invert,
    input  wire logic                  swap_enable,
    output logic                       a_less_b,
    output logic                       swap_execute,
    output logic                       din_gt_top,
    output logic                       swap_at_full,
    output topk_pkg::payload_t         swap_data,
    output topk_pkg::payload_t         min_child,
    output topk_pkg::heap_addr_t       min_child_addr
);

    topk_pkg::payload_t heap_top;
    topk_pkg::payload_t left_op;

    // Value being sifted
    always_ff @(posedge clk) begin
        if (din_take) begin
            swap_data <= din_data;
        end
    end

    // Copy of slot 0, port B checked last as in the RAM
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            heap_top <= '0;
        end else begin
            if (port_a.wen && (port_a.waddr == '0)) begin
                heap_top <= port_a.wdata;
            end
            if (port_b.wen && (port_b.waddr == '0)) begin
                heap_top <= port_b.wdata;
            end
        end
    end

    // Sift-up weighs the new value against its parent,
    // sift-down weighs the left child against the right
    always_comb begin
        case (state)
            topk_pkg::SIFT_UP: left_op = swap_data;
            topk_pkg::SIFT_DN: left_op = port_a.rdata;
            default:           left_op = '0;
        endcase
    end

    assign a_less_b     = left_op < port_b.rdata;
    assign swap_execute = swap_enable && (a_less_b ^ cmp_invert);
    assign din_gt_top   = din_data > heap_top;

    // Left child only when the right one is past the heap end
    assign min_child_addr = (right_ovfl || a_less_b) ? cmp_a_addr : cmp_b_addr;
    assign min_child      = (right_ovfl || a_less_b) ? port_a.rdata : port_b.rdata;
    assign swap_at_full   = min_child < swap_data;

endmodule

`default_nettype wire

/* src/topk_sorter.sv */
// ==============================
// Streaming top-K selector top
// ==============================
`timescale 1ns/100ps
`default_nettype none

module topk_sorter (
    input  wire logic               clk,
    input  wire logic               aresetn,
    input  wire topk_pkg::payload_t s_axis_din_tdata,
    input  wire logic               s_axis_din_tvalid,
    input  wire logic               s_axis_din_tlast,
    output logic                    s_axis_din_tready,
    output topk_pkg::payload_t      m_axis_dout_tdata,
    output logic                    m_axis_dout_tvalid,
    output logic                    m_axis_dout_tlast
);

    topk_pkg::sort_state_e state;
    logic                  din_take;
    topk_pkg::heap_addr_t  cmp_a_addr;
    topk_pkg::heap_addr_t  cmp_b_addr;
    logic                  right_ovfl;
    logic                  cmp_invert;
    logic                  swap_enable;
    logic                  a_less_b;
    logic                  swap_execute;
    logic                  din_gt_top;
    logic                  swap_at_full;
    topk_pkg::payload_t    swap_data;
    topk_pkg::payload_t    min_child;
    topk_pkg::heap_addr_t  min_child_addr;

    heap_port_if port_a ();
    heap_port_if port_b ();

    // Read-out runs on port A
    assign m_axis_dout_tdata = port_a.rdata;

    heap_dpram heap_dpram_inst (
        .clk    (clk),
        .port_a (port_a.ram),
        .port_b (port_b.ram)
    );

    heap_sift_ctrl heap_sift_ctrl_inst (
        .clk            (clk),
        .aresetn        (aresetn),
        .s_tvalid       (s_axis_din_tvalid),
        .s_tlast        (s_axis_din_tlast),
        .s_tdata        (s_axis_din_tdata),
        .s_tready       (s_axis_din_tready),
        .m_tvalid       (m_axis_dout_tvalid),
        .m_tlast        (m_axis_dout_tlast),
        .port_a         (port_a.driver),
        .port_b         (port_b.driver),
        .state          (state),
        .din_take       (din_take),
        .cmp_a_addr     (cmp_a_addr),
        .cmp_b_addr     (cmp_b_addr),
        .right_ovfl     (right_ovfl),
        .cmp_invert     (cmp_invert),
        .swap_enable    (swap_enable),
        .a_less_b       (a_less_b),
        .swap_execute   (swap_execute),
        .din_gt_top     (din_gt_top),
        .swap_at_full   (swap_at_full),
        .swap_data      (swap_data),
        .min_child      (min_child),
        .min_child_addr (min_child_addr)
    );

    heap_compare heap_compare_inst (
        .clk            (clk),
        .aresetn        (aresetn),
        .port_a         (port_a.snoop),
        .port_b         (port_b.snoop),
        .state          (state),
        .din_data       (s_axis_din_tdata),
        .din_take       (din_take),
        .cmp_a_addr     (cmp_a_addr),
        .cmp_b_addr     (cmp_b_addr),
        .right_ovfl     (right_ovfl),
        .cmp_invert     (cmp_invert),
        .swap_enable    (swap_enable),
        .a_less_b       (a_less_b),
        .swap_execute   (swap_execute),
        .din_gt_top     (din_gt_top),
        .swap_at_full   (swap_at_full),
        .swap_data      (swap_data),
        .min_child      (min_child),
        .min_child_addr (min_child_addr)
    );

endmodule

`default_nettype wire

/* bench/topk_sorter_tb.sv */
// ==============================
// Top-K selector testbench with
// stream model and watchdog
// ==============================
`timescale 1ns/100ps
`default_nettype none
`include "topk_defines.svh"

module topk_sorter_tb;

    localparam int K       = `TOPK_DEPTH;
    localparam int AW      = `TOPK_ADDR_WIDTH;
    localparam int MAX_LEN = 3 * K;
    localparam int STREAMS = 4;

    logic               clk = 1'b0;
    logic               aresetn;
    topk_pkg::payload_t s_tdata;
    logic               s_tvalid;
    logic               s_tlast;
    logic               s_tready;
    topk_pkg::payload_t m_tdata;
    logic               m_tvalid;
    logic               m_tlast;

    topk_pkg::payload_t stim [MAX_LEN];
    topk_pkg::payload_t work [MAX_LEN];
    topk_pkg::payload_t expected [K];
    topk_pkg::payload_t out_beats [K];
    int                 stim_len;
    int                 out_count;
    int                 cycle_cnt = 0;
    int                 tlast_cycle;
    int                 err_count;
    int                 tests_run;
    int                 tests_failed;
    string              cur_name;
    logic               last_accepted;
    logic               run_done;

    topk_sorter topk_sorter_inst (
        .clk                (clk),
        .aresetn            (aresetn),
        .s_axis_din_tdata   (s_tdata),
        .s_axis_din_tvalid  (s_tvalid),
        .s_axis_din_tlast   (s_tlast),
        .s_axis_din_tready  (s_tready),
        .m_axis_dout_tdata  (m_tdata),
        .m_axis_dout_tvalid (m_tvalid),
        .m_axis_dout_tlast  (m_tlast)
    );

    initial begin
        forever begin
            #20 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic int stream_length(input int s);
        case (s)
            0:       return 3 * K;
            1:       return K / 2;
            2:       return 1;
            default: return 2 * K;
        endcase
    endfunction

    task automatic report_fail(input string msg);
        $display("Fail at %0d ns: %s", $time, msg);
        err_count = err_count + 1;
    endtask

    // Ascending order over work[0..n-1]
    task automatic sort_work(input int n);
        topk_pkg::payload_t t;
        for (int i = 0; i < n - 1; i++) begin
            for (int j = 0; j < n - 1 - i; j++) begin
                if (work[j] > work[j + 1]) begin
                    t           = work[j];
                    work[j]     = work[j + 1];
                    work[j + 1] = t;
                end
            end
        end
    endtask

    task automatic generate_stream(input int s);
        stim_len = stream_length(s);
        for (int j = 0; j < stim_len; j++) begin
            if (s == 3 && j >= K && ($urandom % 4) == 0) begin
                // Repeat the smallest of the K largest so far
                for (int m = 0; m < j; m++) begin
                    work[m] = stim[m];
                end
                sort_work(j);
                stim[j] = work[j - K];
            end else if (s == 3) begin
                stim[j] = $urandom_range(255, 0);
            end else begin
                stim[j] = $urandom;
            end
        end
    endtask

    // K largest values in ascending order with zeros first for a short stream
    task automatic build_expected();
        int pad;
        for (int i = 0; i < stim_len; i++) begin
            work[i] = stim[i];
        end
        sort_work(stim_len);
        pad = (stim_len < K) ? K - stim_len : 0;
        for (int i = 0; i < K; i++) begin
            if (i < pad) begin
                expected[i] = '0;
            end else begin
                expected[i] = work[stim_len - K + i];
            end
        end
    endtask

    // Starts on a falling edge and returns on the one after the transfer
    task automatic send_beat(input topk_pkg::payload_t data, input logic last);
        int gap;
        gap = (($urandom % 4) == 0) ? 1 + ($urandom % 2) : 0;
        repeat (gap) begin
            s_tvalid = 1'b0;
            @(negedge clk);
        end
        s_tvalid = 1'b1;
        s_tdata  = data;
        s_tlast  = last;
        while (s_tready !== 1'b1) begin
            @(negedge clk);
        end
        @(negedge clk);
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
    endtask

    task automatic check_clear_time(input int ref_cycle, input string what);
        int delay;
        while (s_tready !== 1'b1) begin
            @(negedge clk);
        end
        delay = cycle_cnt - ref_cycle;
        if (delay != K / 2 + 1) begin
            report_fail($sformatf("tready rose %0d cycles after %s, expected %0d",
                                  delay, what, K / 2 + 1));
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run = tests_run + 1;
        if (err_count == errs_before) begin
            $display("Test %s: passed", name);
        end else begin
            $display("Test %s: failed with %0d errors", name, err_count - errs_before);
            tests_failed = tests_failed + 1;
        end
    endtask

    task automatic run_stream(input int s, input string name);
        int errs_before;
        int heap_n;
        errs_before = err_count;
        cur_name    = name;
        generate_stream(s);
        build_expected();
        out_count     = 0;
        run_done      = 1'b0;
        last_accepted = 1'b0;
        for (int i = 0; i < stim_len; i++) begin
            send_beat(stim[i], i == stim_len - 1);
        end
        last_accepted = 1'b1;
        while (!run_done) begin
            @(negedge clk);
        end
        check_clear_time(tlast_cycle, "the closing output beat");
        for (int i = 0; i < K; i++) begin
            work[i] = out_beats[i];
        end
        sort_work(K);
        for (int i = 0; i < K; i++) begin
            if (work[i] !== expected[i]) begin
                report_fail($sformatf("%s sorted beat %0d is %h, expected %h",
                                      name, i, work[i], expected[i]));
            end
        end
        // Min-heap order over the filled slots only
        heap_n = (stim_len < K) ? stim_len : K;
        for (int i = 1; i < heap_n; i++) begin
            if (out_beats[i] < out_beats[(i - 1) / 2]) begin
                report_fail($sformatf("%s slot %0d holds %h, below its parent %h",
                                      name, i, out_beats[i], out_beats[(i - 1) / 2]));
            end
        end
        report_test(name, errs_before);
    endtask

    // Output framing sampled mid-cycle
    always @(negedge clk) begin
        if (aresetn === 1'b1) begin
            if (m_tvalid) begin
                if (s_tready) begin
                    report_fail("output beat while tready is high");
                end
                if (!last_accepted) begin
                    report_fail("output beat before the closing input beat");
                end
                if (run_done) begin
                    report_fail("output beat after tlast");
                end else begin
                    if (out_count < K) begin
                        out_beats[out_count] = m_tdata;
                    end
                    out_count = out_count + 1;
                    if (m_tlast) begin
                        if (out_count != K) begin
                            report_fail($sformatf("tlast on beat %0d, expected on beat %0d",
                                                  out_count - 1, K - 1));
                        end
                        run_done    = 1'b1;
                        tlast_cycle = cycle_cnt;
                    end else if (out_count == K) begin
                        report_fail("tlast missing on the last beat");
                    end
                end
            end else begin
                if (m_tlast) begin
                    report_fail("tlast high without tvalid");
                end
                if (out_count > 0 && !run_done) begin
                    report_fail("gap inside an output run");
                end
            end
        end
    end

    initial begin : watchdog
        int limit;
        limit = 5 + K / 2 + 10;
        for (int s = 0; s < STREAMS; s++) begin
            limit = limit + stream_length(s) * (2 * AW + 4) + 2 * K + K / 2 + 10;
        end
        repeat (limit) @(posedge clk);
        $display("Timeout after %0d cycles, the run hung in test %s", limit, cur_name);
        $display(">>> FAIL");
        $finish;
    end

    initial begin : main_flow
        int errs_before;
        aresetn       = 1'b0;
        s_tdata       = '0;
        s_tvalid      = 1'b0;
        s_tlast       = 1'b0;
        err_count     = 0;
        tests_run     = 0;
        tests_failed  = 0;
        out_count     = 0;
        run_done      = 1'b0;
        last_accepted = 1'b0;
        stim_len      = 0;
        tlast_cycle   = 0;
        cur_name      = "reset and clear";
        void'($urandom(32'hca8d));

        errs_before = err_count;
        repeat (5) @(negedge clk);
        if (s_tready !== 1'b0 || m_tvalid !== 1'b0 || m_tlast !== 1'b0) begin
            report_fail("tready, tvalid or tlast not low in reset");
        end
        aresetn = 1'b1;
        check_clear_time(cycle_cnt, "reset release");
        report_test("reset and clear", errs_before);

        run_stream(0, "replace with 3K values");
        run_stream(1, "short stream of K/2 values");
        run_stream(2, "single value");
        run_stream(3, "back-to-back with ties");

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d check errors",
                 tests_run, tests_run - tests_failed, tests_failed, err_count);
        if (err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+include
src/topk_pkg.sv
src/heap_port_if.sv
src/heap_dpram.sv
src/heap_sift_ctrl.sv
src/heap_compare.sv
src/topk_sorter.sv
bench/topk_sorter_tb.sv

/* Bender.yml */
package:
  name: topk_sorter

sources:
  - include_dirs:
      - include
    files:
      - src/topk_pkg.sv
      - src/heap_port_if.sv
      - src/heap_dpram.sv
      - src/heap_sift_ctrl.sv
      - src/heap_compare.sv
      - src/topk_sorter.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/topk_sorter_tb.sv
